// File: src/abacus_bus_pkg.sv
package abacus_bus_pkg;

	// Wishbone word and address sizes
	localparam int BUS_DATA_WIDTH = 32;
	localparam int BUS_ADDR_WIDTH = 32;

	typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;
	typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;

	// Byte distance between two neighbouring registers
	localparam int REG_STRIDE = 4;

	// Register map, all word aligned
	localparam bus_addr_t ABACUS_BASE_ADDR = 32'hf0030000;

	localparam bus_addr_t INSTR_ENABLE_ADDR = ABACUS_BASE_ADDR + 32'h0004;
	localparam bus_addr_t CACHE_ENABLE_ADDR = ABACUS_BASE_ADDR + 32'h0008;

	// Eleven class counters in class order
	localparam bus_addr_t INSTR_COUNTER_BASE = ABACUS_BASE_ADDR + 32'h0100;

	// Icache request, hit, miss, fill, then the same four for the dcache
	localparam bus_addr_t CACHE_COUNTER_BASE = ABACUS_BASE_ADDR + 32'h0200;

	// Master side of one Wishbone classic transfer
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		bus_addr_t adr;
		bus_data_t dat;
	} wb_req_t;

endpackage

// File: src/abacus_event_pkg.sv
package abacus_event_pkg;

	// Counters are free running and wrap at 2^32
	localparam int COUNTER_WIDTH = 32;

	typedef logic [COUNTER_WIDTH-1:0] counter_t;

	// One strobe per instruction class
	// First member maps to counter 0
	typedef struct packed {
		logic load_word;
		logic store_word;
		logic addition;
		logic subtraction;
		logic logical;
		logic shift;
		logic comparison;
		logic branch;
		logic jump;
		logic system;
		logic atomic;
	} instr_events_t;

	localparam int NUM_INSTR_CLASSES = 11;

	// Raw probes from the two caches
	typedef struct packed {
		logic icache_request;
		logic icache_miss;
		logic icache_fill;     // level, high while a line fill runs
		logic dcache_request;
		logic dcache_hit;
		logic dcache_fill;
	} cache_probe_t;

	// Qualified cache events in counter order
	typedef struct packed {
		logic icache_request;
		logic icache_hit;
		logic icache_miss;
		logic icache_fill;
		logic dcache_request;
		logic dcache_hit;
		logic dcache_miss;
		logic dcache_fill;
	} cache_events_t;

	localparam int NUM_CACHE_EVENTS = 8;

	// RISC-V major opcodes
	typedef logic [6:0] opcode_t;

	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;
	localparam opcode_t OPC_AMO    = 7'b0101111;

	// Funct7 values that split add from sub
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// File: src/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier
	import abacus_bus_pkg::*;
	import abacus_event_pkg::*;
(
	input  logic          S_AXI_ACLK,
	input  logic          rst,
	input  bus_data_t     instruction_i,
	input  logic          instruction_issued_i,
	output instr_events_t events_o
);

	opcode_t       opcode;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	logic          is_alu;
	instr_events_t class_d;

	// RV32 base encoding fields
	assign opcode = instruction_i[6:0];
	assign funct3 = instruction_i[14:12];
	assign funct7 = instruction_i[31:25];

	// Register and immediate ALU forms share the funct3 split
	assign is_alu = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);

	always_comb
	begin
		class_d = '0;
		case (opcode)
			OPC_LOAD:
				class_d.load_word = (funct3 == 3'b010);
			OPC_STORE:
				class_d.store_word = (funct3 == 3'b010);
			OPC_BRANCH:
				class_d.branch = 1'b1;
			OPC_JAL, OPC_JALR:
				class_d.jump = 1'b1;
			OPC_SYSTEM:
				class_d.system = 1'b1;
			OPC_AMO:
				class_d.atomic = 1'b1;
			default:
			begin
				if (is_alu)
				begin
					case (funct3)
						3'b000:
						begin
							// Immediate form has no sub, so addi always adds
							if (opcode == OPC_OP_IMM)
								class_d.addition = 1'b1;
							else if (funct7 == FUNCT7_BASE)
								class_d.addition = 1'b1;
							else if (funct7 == FUNCT7_ALT)
								class_d.subtraction = 1'b1;
						end
						3'b100, 3'b110, 3'b111:
							class_d.logical = 1'b1;
						3'b001, 3'b101:
							class_d.shift = 1'b1;
						default:
							class_d.comparison = 1'b1;
					endcase
				end
			end
		endcase
	end

	// Result is only kept for an issued instruction, otherwise all strobes drop
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
			events_o <= '0;
		else if (instruction_issued_i)
			events_o <= class_d;
		else
			events_o <= '0;
	end

endmodule

// File: src/cache_event_capture.sv
`timescale 1ns/1ps

module cache_event_capture
	import abacus_event_pkg::*;
(
	input  logic          S_AXI_ACLK,
	input  logic          rst,
	input  cache_probe_t  probe_i,
	output cache_events_t events_o
);

	cache_events_t events_d;

	always_comb
	begin
		events_d = '0;

		// Icache reports misses, a request without a miss is a hit
		events_d.icache_request = probe_i.icache_request;
		events_d.icache_hit     = probe_i.icache_request & ~probe_i.icache_miss;
		events_d.icache_miss    = probe_i.icache_request & probe_i.icache_miss;

		// Dcache reports hits, a request without a hit is a miss
		events_d.dcache_request = probe_i.dcache_request;
		events_d.dcache_hit     = probe_i.dcache_request & probe_i.dcache_hit;
		events_d.dcache_miss    = probe_i.dcache_request & ~probe_i.dcache_hit;

		// Fill levels count one per cycle, independent of any request
		events_d.icache_fill = probe_i.icache_fill;
		events_d.dcache_fill = probe_i.dcache_fill;
	end

	// Registered every cycle, so idle probes give an all zero struct
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
			events_o <= '0;
		else
			events_o <= events_d;
	end

endmodule

// File: src/event_counter_bank.sv
`timescale 1ns/1ps

module event_counter_bank
	import abacus_event_pkg::*;
#(
	parameter type event_t = logic,
	localparam int N = $bits(event_t)
)
(
	input  logic     S_AXI_ACLK,
	input  logic     rst,
	input  logic     enable_i,
	input  event_t   events_i,
	output counter_t counts_o [N]
);

	logic [N-1:0] event_bits;

	// Flatten the struct, first member lands in the top bit
	assign event_bits = events_i;

	// Counter i follows struct member i, so index from the top bit down
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < N; i++)
				counts_o[i] <= '0;
		end
		else if (enable_i)
		begin
			for (int i = 0; i < N; i++)
				counts_o[i] <= counts_o[i] + counter_t'(event_bits[N-1-i]);
		end
	end

endmodule

// File: src/wb_register_file.sv
`timescale 1ns/1ps

module wb_register_file
	import abacus_bus_pkg::*;
	import abacus_event_pkg::*;
(
	input  logic      S_AXI_ACLK,
	input  logic      rst,
	input  wb_req_t   wb_req_i,
	input  counter_t  instr_counts_i [NUM_INSTR_CLASSES],
	input  counter_t  cache_counts_i [NUM_CACHE_EVENTS],
	output bus_data_t wb_dat_o,
	output logic      wb_ack_o,
	output logic      instr_enable_o,
	output logic      cache_enable_o
);

	bus_data_t instr_enable_q;
	bus_data_t cache_enable_q;
	logic      req_valid;
	logic      rd_req;
	logic      wr_req;

	assign req_valid = wb_req_i.cyc & wb_req_i.stb;
	assign rd_req    = req_valid & ~wb_req_i.we;
	assign wr_req    = req_valid & wb_req_i.we;

	// Only bit 0 switches a profiler on, the rest is plain storage
	assign instr_enable_o = instr_enable_q[0];
	assign cache_enable_o = cache_enable_q[0];

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			wb_ack_o       <= 1'b0;
			instr_enable_q <= '0;
			cache_enable_q <= '0;
		end
		else
		begin
			// Ack drops after one cycle even with stb still high
			wb_ack_o <= req_valid & ~wb_ack_o;

			if (wr_req)
			begin
				case (wb_req_i.adr)
					INSTR_ENABLE_ADDR:
						instr_enable_q <= wb_req_i.dat;
					CACHE_ENABLE_ADDR:
						cache_enable_q <= wb_req_i.dat;
					default:
					begin
						// Counters are read only, other writes are dropped
					end
				endcase
			end
		end
	end

	// Read mux, unmapped addresses and idle bus give zero
	always_comb
	begin
		wb_dat_o = '0;
		if (rd_req)
		begin
			if (wb_req_i.adr == INSTR_ENABLE_ADDR)
				wb_dat_o = instr_enable_q;
			if (wb_req_i.adr == CACHE_ENABLE_ADDR)
				wb_dat_o = cache_enable_q;

			for (int i = 0; i < NUM_INSTR_CLASSES; i++)
			begin
				if (wb_req_i.adr == INSTR_COUNTER_BASE + bus_addr_t'(REG_STRIDE * i))
					wb_dat_o = instr_counts_i[i];
			end

			for (int i = 0; i < NUM_CACHE_EVENTS; i++)
			begin
				if (wb_req_i.adr == CACHE_COUNTER_BASE + bus_addr_t'(REG_STRIDE * i))
					wb_dat_o = cache_counts_i[i];
			end
		end
	end

endmodule

// File: src/abacus_top.sv
`timescale 1ns/1ps

module abacus_top
	import abacus_bus_pkg::*;
	import abacus_event_pkg::*;
(
	input  logic         S_AXI_ACLK,
	input  logic         rst,

	// Issue stage of the core
	input  bus_data_t    instruction_i,
	input  logic         instruction_issued_i,

	// Cache probes
	input  cache_probe_t cache_probe_i,

	// Wishbone slave port
	input  wb_req_t      wb_req_i,
	output bus_data_t    wb_dat_o,
	output logic         wb_ack_o
);

	instr_events_t instr_events;
	cache_events_t cache_events;
	counter_t      instr_counts [NUM_INSTR_CLASSES];
	counter_t      cache_counts [NUM_CACHE_EVENTS];
	logic          instr_enable;
	logic          cache_enable;

	// Instruction path, classify then count
	instr_classifier u_instr_classifier (
		.S_AXI_ACLK           (S_AXI_ACLK),
		.rst                  (rst),
		.instruction_i        (instruction_i),
		.instruction_issued_i (instruction_issued_i),
		.events_o             (instr_events)
	);

	event_counter_bank #(
		.event_t (instr_events_t)
	) u_instr_counters (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.enable_i   (instr_enable),
		.events_i   (instr_events),
		.counts_o   (instr_counts)
	);

	// Cache path, qualify probes then count
	cache_event_capture u_cache_capture (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.probe_i    (cache_probe_i),
		.events_o   (cache_events)
	);

	event_counter_bank #(
		.event_t (cache_events_t)
	) u_cache_counters (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.enable_i   (cache_enable),
		.events_i   (cache_events),
		.counts_o   (cache_counts)
	);

	// Enables and counter readout
	wb_register_file u_regs (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.rst            (rst),
		.wb_req_i       (wb_req_i),
		.instr_counts_i (instr_counts),
		.cache_counts_i (cache_counts),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.instr_enable_o (instr_enable),
		.cache_enable_o (cache_enable)
	);

endmodule

// File: verification/abacus_checker.sv
`timescale 1ns/1ps

module abacus_checker
	import abacus_bus_pkg::*;
	import abacus_event_pkg::*;
(
	input  logic         S_AXI_ACLK,
	input  logic         rst,
	input  bus_data_t    instruction_i,
	input  logic         instruction_issued_i,
	input  cache_probe_t cache_probe_i,
	input  wb_req_t      wb_req_i,
	input  bus_data_t    wb_dat_i,
	input  logic         wb_ack_i,
	output int           error_count_o,
	output int           read_count_o
);

	localparam int ACK_LIMIT = 4;

	bus_data_t     shadow_instr_en;
	bus_data_t     shadow_cache_en;
	instr_events_t instr_stage;
	cache_events_t cache_stage;
	counter_t      exp_instr [NUM_INSTR_CLASSES];
	counter_t      exp_cache [NUM_CACHE_EVENTS];
	logic          ack_seen;
	int            ack_wait;

	function automatic instr_events_t classify(input bus_data_t instr);
		opcode_t       op;
		logic [2:0]    f3;
		logic [6:0]    f7;
		logic          alu;
		instr_events_t ev;
		op  = instr[6:0];
		f3  = instr[14:12];
		f7  = instr[31:25];
		alu = (op == OPC_OP) || (op == OPC_OP_IMM);
		ev.load_word   = (op == OPC_LOAD) && (f3 == 3'b010);
		ev.store_word  = (op == OPC_STORE) && (f3 == 3'b010);
		ev.addition    = (f3 == 3'b000)
			&& ((op == OPC_OP_IMM) || (op == OPC_OP && f7 == 7'b0000000));
		ev.subtraction = (op == OPC_OP) && (f3 == 3'b000) && (f7 == 7'b0100000);
		ev.logical     = alu && (f3 == 3'b100 || f3 == 3'b110 || f3 == 3'b111);
		ev.shift       = alu && (f3 == 3'b001 || f3 == 3'b101);
		ev.comparison  = alu && (f3 == 3'b010 || f3 == 3'b011);
		ev.branch      = (op == OPC_BRANCH);
		ev.jump        = (op == OPC_JAL) || (op == OPC_JALR);
		ev.system      = (op == OPC_SYSTEM);
		ev.atomic      = (op == OPC_AMO);
		return ev;
	endfunction

	function automatic cache_events_t cache_reference(input cache_probe_t p);
		cache_events_t ev;
		ev.icache_request = p.icache_request;
		ev.icache_hit     = p.icache_request && !p.icache_miss;
		ev.icache_miss    = p.icache_request && p.icache_miss;
		ev.icache_fill    = p.icache_fill;
		ev.dcache_request = p.dcache_request;
		ev.dcache_hit     = p.dcache_request && p.dcache_hit;
		ev.dcache_miss    = p.dcache_request && !p.dcache_hit;
		ev.dcache_fill    = p.dcache_fill;
		return ev;
	endfunction

	function automatic bus_data_t expected_read(input bus_addr_t addr);
		if (addr == INSTR_ENABLE_ADDR)
			return shadow_instr_en;
		if (addr == CACHE_ENABLE_ADDR)
			return shadow_cache_en;
		for (int i = 0; i < NUM_INSTR_CLASSES; i++)
			if (addr == INSTR_COUNTER_BASE + bus_addr_t'(4 * i))
				return exp_instr[i];
		for (int i = 0; i < NUM_CACHE_EVENTS; i++)
			if (addr == CACHE_COUNTER_BASE + bus_addr_t'(4 * i))
				return exp_cache[i];
		return '0;
	endfunction

	initial
	begin
		error_count_o = 0;
		read_count_o  = 0;
		ack_seen      = 1'b0;
		ack_wait      = 0;
	end

	// Two stage shadow of the event paths
	always @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			shadow_instr_en = '0;
			shadow_cache_en = '0;
			instr_stage     = '0;
			cache_stage     = '0;
			for (int i = 0; i < NUM_INSTR_CLASSES; i++)
				exp_instr[i] = '0;
			for (int i = 0; i < NUM_CACHE_EVENTS; i++)
				exp_cache[i] = '0;
		end
		else
		begin
			// Counters use the events and enables from before this edge
			for (int i = 0; i < NUM_INSTR_CLASSES; i++)
				if (shadow_instr_en[0] && instr_stage[NUM_INSTR_CLASSES-1-i])
					exp_instr[i] = exp_instr[i] + 1;
			for (int i = 0; i < NUM_CACHE_EVENTS; i++)
				if (shadow_cache_en[0] && cache_stage[NUM_CACHE_EVENTS-1-i])
					exp_cache[i] = exp_cache[i] + 1;
			instr_stage = instruction_issued_i ? classify(instruction_i) : '0;
			cache_stage = cache_reference(cache_probe_i);
			if (wb_req_i.cyc && wb_req_i.stb && wb_req_i.we)
			begin
				if (wb_req_i.adr == INSTR_ENABLE_ADDR)
					shadow_instr_en = wb_req_i.dat;
				if (wb_req_i.adr == CACHE_ENABLE_ADDR)
					shadow_cache_en = wb_req_i.dat;
			end
		end
	end

	// Bus checks half a cycle after each edge
	always @(negedge S_AXI_ACLK)
	begin
		if (!rst)
		begin
			if (wb_ack_i && ack_seen)
			begin
				$display("Error at %0t: acknowledge stayed high for two cycles", $time);
				error_count_o++;
			end
			ack_seen = wb_ack_i;
			if (wb_ack_i && wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we)
			begin
				read_count_o++;
				if (wb_dat_i !== expected_read(wb_req_i.adr))
				begin
					$display("mismatch at %0t: address %h read %h, expected %h", $time,
						wb_req_i.adr, wb_dat_i, expected_read(wb_req_i.adr));
					error_count_o++;
				end
			end
			// Read data stays zero while no read is requested
			if (!(wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we) && wb_dat_i !== '0)
			begin
				$display("mismatch at %0t: read data %h without a read request, expected 0",
					$time, wb_dat_i);
				error_count_o++;
			end
			if (wb_req_i.cyc && wb_req_i.stb && !wb_ack_i)
				ack_wait++;
			else
				ack_wait = 0;
			if (ack_wait > ACK_LIMIT)
			begin
				$display("Error at %0t: no acknowledge for the request to address %h",
					$time, wb_req_i.adr);
				error_count_o++;
				ack_wait = 0;
			end
		end
	end

endmodule

// File: verification/abacus_tb.sv
`timescale 1ns/1ps

module abacus_tb
	import abacus_bus_pkg::*;
	import abacus_event_pkg::*;
();

	localparam int RESET_CYCLES  = 16;
	localparam int MIXED_CYCLES  = 20;
	localparam int MAIN_CYCLES   = 300;
	localparam int GATED_CYCLES  = 100;
	localparam int IDLE_CYCLES   = 3;
	localparam int ACCESS_COUNT  = 120;
	localparam int ACCESS_CYCLES = 2;
	localparam int ACK_WAIT      = 8;

	// Event phases plus every bus access and idle gap
	localparam int PHASE_SUM = RESET_CYCLES + MIXED_CYCLES + MAIN_CYCLES + 2 * GATED_CYCLES
		+ ACCESS_COUNT * ACCESS_CYCLES + 12 * IDLE_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * PHASE_SUM;

	logic         S_AXI_ACLK;
	logic         rst;
	bus_data_t    instruction;
	logic         instruction_issued;
	cache_probe_t cache_probe;
	wb_req_t      wb_req;
	bus_data_t    wb_dat;
	logic         wb_ack;
	logic [15:0]  lfsr_state;
	int           cycle_count;
	int           error_count;
	int           read_count;

	abacus_top UUT (
		.S_AXI_ACLK           (S_AXI_ACLK),
		.rst                  (rst),
		.instruction_i        (instruction),
		.instruction_issued_i (instruction_issued),
		.cache_probe_i        (cache_probe),
		.wb_req_i             (wb_req),
		.wb_dat_o             (wb_dat),
		.wb_ack_o             (wb_ack)
	);

	abacus_checker u_checker (
		.S_AXI_ACLK           (S_AXI_ACLK),
		.rst                  (rst),
		.instruction_i        (instruction),
		.instruction_issued_i (instruction_issued),
		.cache_probe_i        (cache_probe),
		.wb_req_i             (wb_req),
		.wb_dat_i             (wb_dat),
		.wb_ack_i             (wb_ack),
		.error_count_o        (error_count),
		.read_count_o         (read_count)
	);

	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Sample encodings, lb and lui fall in no class
	function automatic bus_data_t sample_instruction(input logic [3:0] idx);
		case (idx)
			4'd0:    return 32'h0000a083;  // lw
			4'd1:    return 32'h00008083;  // lb
			4'd2:    return 32'h0010a023;  // sw
			4'd3:    return 32'h00108093;  // addi
			4'd4:    return 32'h002080b3;  // add
			4'd5:    return 32'h402080b3;  // sub
			4'd6:    return 32'h0020c0b3;  // xor
			4'd7:    return 32'h002090b3;  // sll
			4'd8:    return 32'h4010d093;  // srai
			4'd9:    return 32'h0020a0b3;  // slt
			4'd10:   return 32'h00208463;  // beq
			4'd11:   return 32'h008000ef;  // jal
			4'd12:   return 32'h000080e7;  // jalr
			4'd13:   return 32'h00000073;  // ecall
			4'd14:   return 32'h0020a0af;  // amoadd.w
			default: return 32'h123450b7;  // lui
		endcase
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge S_AXI_ACLK);
		#2;
	endtask

	// Request is held through the ack cycle and dropped after the next edge
	task automatic wb_access(input bus_addr_t addr, input logic write, input bus_data_t data);
		int waited;
		waited     = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = write;
		wb_req.adr = addr;
		wb_req.dat = data;
		@(negedge S_AXI_ACLK);
		while (!wb_ack && waited < ACK_WAIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		@(posedge S_AXI_ACLK);
		#2;
		wb_req = '0;
	endtask

	task automatic read_all();
		wb_access(INSTR_ENABLE_ADDR, 1'b0, '0);
		wb_access(CACHE_ENABLE_ADDR, 1'b0, '0);
		for (int i = 0; i < NUM_INSTR_CLASSES; i++)
			wb_access(INSTR_COUNTER_BASE + bus_addr_t'(4 * i), 1'b0, '0);
		for (int i = 0; i < NUM_CACHE_EVENTS; i++)
			wb_access(CACHE_COUNTER_BASE + bus_addr_t'(4 * i), 1'b0, '0);
	endtask

	task automatic set_enables(input bus_data_t instr_val, input bus_data_t cache_val);
		wb_access(INSTR_ENABLE_ADDR, 1'b1, instr_val);
		wb_access(CACHE_ENABLE_ADDR, 1'b1, cache_val);
	endtask

	task automatic run_events(input int cycles);
		logic [31:0] pick;
		logic [31:0] issue;
		logic [31:0] probe;
		for (int c = 0; c < cycles; c++)
		begin
			random_bits(4, pick);
			random_bits(1, issue);
			random_bits(6, probe);
			instruction        = sample_instruction(pick[3:0]);
			instruction_issued = issue[0];
			cache_probe        = cache_probe_t'(probe[5:0]);
			@(posedge S_AXI_ACLK);
			#2;
		end
		instruction        = '0;
		instruction_issued = 1'b0;
		cache_probe        = '0;
	endtask

	initial
	begin
		S_AXI_ACLK         = 1'b0;
		rst                = 1'b1;
		instruction        = '0;
		instruction_issued = 1'b0;
		cache_probe        = '0;
		wb_req             = '0;
		lfsr_state         = 16'd55580;
		cycle_count        = 0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		#2;
		rst = 1'b0;
		idle(IDLE_CYCLES);
		read_all();

		// Bit 0 set in the instr word only
		set_enables(32'hdeadbeef, 32'h12345678);
		run_events(MIXED_CYCLES);
		idle(IDLE_CYCLES);
		read_all();

		set_enables(32'h1, 32'h1);
		run_events(MAIN_CYCLES);
		idle(IDLE_CYCLES);
		read_all();

		// Counters hold while off and resume afterwards
		set_enables(32'h0, 32'h0);
		run_events(GATED_CYCLES);
		idle(IDLE_CYCLES);
		read_all();
		set_enables(32'h1, 32'h1);
		run_events(GATED_CYCLES);
		idle(IDLE_CYCLES);
		read_all();

		// Holes in the map
		wb_access(ABACUS_BASE_ADDR, 1'b0, '0);
		wb_access(ABACUS_BASE_ADDR + 32'h00c, 1'b0, '0);
		wb_access(INSTR_COUNTER_BASE + 32'h02c, 1'b0, '0);
		wb_access(CACHE_COUNTER_BASE + 32'h020, 1'b0, '0);
		idle(IDLE_CYCLES);

		$display("Summary: %0d reads checked, %0d errors", read_count, error_count);
		if (error_count == 0 && read_count > 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: abacus_top.f
src/abacus_bus_pkg.sv
src/abacus_event_pkg.sv
src/instr_classifier.sv
src/cache_event_capture.sv
src/event_counter_bank.sv
src/wb_register_file.sv
src/abacus_top.sv
verification/abacus_checker.sv
verification/abacus_tb.sv

// File: Bender.yml
package:
  name: abacus

sources:
  # Packages first, the modules import them
  - files:
      - src/abacus_bus_pkg.sv
      - src/abacus_event_pkg.sv
      - src/instr_classifier.sv
      - src/cache_event_capture.sv
      - src/event_counter_bank.sv
      - src/wb_register_file.sv
      - src/abacus_top.sv

  - target: simulation
    files:
      - verification/abacus_checker.sv
      - verification/abacus_tb.sv
